// File: common/tcdm_burst_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TCDM burst front end parameters
// Bank geometry, word and address widths shared by all blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TCDM_BURST_DEFINES_SVH
`define TCDM_BURST_DEFINES_SVH

`define TCDM_NUM_BANKS       8                // Banks per row
`define TCDM_MAX_BURST       `TCDM_NUM_BANKS  // Longest burst, one cut at most
`define TCDM_NUM_ROWS        16               // Words per bank
`define TCDM_DATA_WIDTH      32
`define TCDM_ADDR_WIDTH      32               // Byte address
`define TCDM_ID_WIDTH        4                // Initiator ID
`define TCDM_BYTE_OFF_WIDTH  2                // Byte offset inside a word

`endif

// File: common/tcdm_burst_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TCDM burst types
// Burst descriptor and the word, row and index types of the front end
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "tcdm_burst_defines.svh"

package tcdm_burst_pkg;

  // 0 .. max burst, so one bit wider than the bank index
  typedef logic [$clog2(`TCDM_MAX_BURST+1)-1:0] blen_t;

  typedef struct packed {
    logic  isburst;  // Set for a burst, clear for a single word
    blen_t blen;     // Words in the burst
  } burst_t;

  typedef logic [`TCDM_DATA_WIDTH-1:0]   data_t;
  typedef logic [`TCDM_DATA_WIDTH/8-1:0] be_t;
  typedef logic [`TCDM_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`TCDM_ID_WIDTH-1:0]     id_t;

  typedef logic [$clog2(`TCDM_NUM_BANKS)-1:0] bank_idx_t;  // Bank inside a row
  typedef logic [$clog2(`TCDM_NUM_ROWS)-1:0]  row_idx_t;   // Row inside a bank

  // Response payload, word k is the k-th word of the burst
  typedef data_t [`TCDM_NUM_BANKS-1:0] row_data_t;

endpackage

// File: hdl/tcdm_burst_cutter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Burst cutter
// Splits a read burst that crosses the end of a bank row into two
// row-local cuts, other requests pass through unchanged
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "tcdm_burst_defines.svh"

module tcdm_burst_cutter (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Request in
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  tcdm_burst_pkg::id_t       req_ini_addr_i,  // Initiator ID
  input  tcdm_burst_pkg::addr_t     req_tgt_addr_i,  // Byte address
  input  logic                      req_wen_i,
  input  tcdm_burst_pkg::data_t     req_wdata_i,
  input  tcdm_burst_pkg::be_t       req_be_i,
  input  tcdm_burst_pkg::burst_t    req_burst_i,
  // Request out, row-local
  output logic                      req_valid_o,
  input  logic                      req_ready_i,
  output tcdm_burst_pkg::id_t       req_ini_addr_o,
  output tcdm_burst_pkg::addr_t     req_tgt_addr_o,
  output logic                      req_wen_o,
  output tcdm_burst_pkg::data_t     req_wdata_o,
  output tcdm_burst_pkg::be_t       req_be_o,
  output tcdm_burst_pkg::burst_t    req_burst_o,
  output logic                      req_split_o      // First cut, second one follows
);

  import tcdm_burst_pkg::*;

  typedef enum logic {
    Bypass,   // Pass through, or send first cut
    BurstCut  // Send stored second cut
  } cut_state_e;

  cut_state_e state_d, state_q;

  // Second cut, loaded when the first cut transfers
  id_t   cut_ini_addr_q;
  addr_t cut_tgt_addr_q;
  blen_t cut_blen_q;

  bank_idx_t bank_idx;   // Start bank of the request
  blen_t     room;       // Words left in the row from the start bank
  logic      need_cut;
  logic      store_cut;

  assign bank_idx  = req_tgt_addr_i[`TCDM_BYTE_OFF_WIDTH +: $bits(bank_idx_t)];
  assign room      = blen_t'(`TCDM_NUM_BANKS) - blen_t'(bank_idx);
  assign need_cut  = req_valid_i & req_burst_i.isburst & ~req_wen_i
                   & (req_burst_i.blen > room);  // Only read bursts get cut
  assign store_cut = (state_q == Bypass) & need_cut & req_ready_i;

  always_comb begin
    state_d = state_q;
    if (store_cut) begin
      state_d = BurstCut;
    end else if (state_q == BurstCut && req_ready_i) begin
      state_d = Bypass;  // Second cut gone
    end
  end

  always_comb begin
    case (state_q)
      BurstCut: begin
        req_valid_o    = 1'b1;
        req_ini_addr_o = cut_ini_addr_q;
        req_tgt_addr_o = cut_tgt_addr_q;
        req_wen_o      = 1'b0;  // Read only
        req_wdata_o    = '0;
        req_be_o       = '0;
        req_burst_o    = '{isburst: 1'b1, blen: cut_blen_q};
        req_split_o    = 1'b0;
        req_ready_o    = req_ready_i;  // Upstream retires with the second cut
      end
      default: begin
        req_valid_o    = req_valid_i;
        req_ini_addr_o = req_ini_addr_i;
        req_tgt_addr_o = req_tgt_addr_i;
        req_wen_o      = req_wen_i;
        req_wdata_o    = req_wdata_i;
        req_be_o       = req_be_i;
        req_burst_o    = req_burst_i;
        req_split_o    = 1'b0;
        req_ready_o    = req_ready_i;
        if (req_wen_i) begin
          req_burst_o = '0;  // Write bursts run as one word
        end else if (need_cut) begin
          req_burst_o.blen = room;  // Up to the row end
          req_split_o      = 1'b1;
          req_ready_o      = 1'b0;  // Hold upstream until the second cut
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Bypass;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (store_cut) begin
      cut_ini_addr_q <= req_ini_addr_i;  // ID unchanged
      cut_tgt_addr_q <= req_tgt_addr_i + (addr_t'(room) << `TCDM_BYTE_OFF_WIDTH);
      cut_blen_q     <= req_burst_i.blen - room;  // Remainder in next row
    end
  end

  // Longer bursts would need more than one cut
  a_blen_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i && req_burst_i.isburst |-> req_burst_i.blen <= `TCDM_MAX_BURST)
    else $error("Burst longer than one row");

  // Stalled output holds its payload
  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_o && !req_ready_i |=> req_valid_o
      && $stable({req_ini_addr_o, req_tgt_addr_o, req_wen_o, req_wdata_o,
                  req_be_o, req_burst_o, req_split_o}))
    else $error("Cut changed while stalled");

endmodule

// File: tcdm_bank_array/tcdm_bank_array.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Banked word memory
// Reads all words of a row-local cut in one cycle, one stalling stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "tcdm_burst_defines.svh"

module tcdm_bank_array (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Cut from the cutter
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  tcdm_burst_pkg::id_t       req_ini_addr_i,
  input  tcdm_burst_pkg::addr_t     req_tgt_addr_i,
  input  logic                      req_wen_i,
  input  tcdm_burst_pkg::data_t     req_wdata_i,
  input  tcdm_burst_pkg::be_t       req_be_i,
  input  tcdm_burst_pkg::burst_t    req_burst_i,
  input  logic                      req_split_i,
  // Read data to the merger
  output logic                      rd_valid_o,
  input  logic                      rd_ready_i,
  output tcdm_burst_pkg::id_t       rd_ini_addr_o,
  output tcdm_burst_pkg::blen_t     rd_blen_o,
  output logic                      rd_split_o,
  output tcdm_burst_pkg::row_data_t rd_data_o
);

  import tcdm_burst_pkg::*;

  data_t mem_q [`TCDM_NUM_BANKS][`TCDM_NUM_ROWS];  // One array per bank

  addr_t     word_addr;
  bank_idx_t bank;
  row_idx_t  row;
  blen_t     req_len;  // Single word counts as 1
  row_data_t rd_row;   // Rotated, first word at index 0
  logic      accept;

  assign word_addr   = req_tgt_addr_i >> `TCDM_BYTE_OFF_WIDTH;
  assign bank        = word_addr[0 +: $bits(bank_idx_t)];
  assign row         = word_addr[$bits(bank_idx_t) +: $bits(row_idx_t)];  // Wraps at row count
  assign req_len     = req_burst_i.isburst ? req_burst_i.blen : blen_t'(1);
  assign req_ready_o = !rd_valid_o || rd_ready_i;  // Empty or draining
  assign accept      = req_valid_i && req_ready_o;

  always_comb begin
    for (int k = 0; k < `TCDM_NUM_BANKS; k++) begin
      if (k < int'(req_len)) begin
        rd_row[k] = mem_q[bank_idx_t'(int'(bank) + k)][row];
      end else begin
        rd_row[k] = '0;  // Unused words stay zero for the merger
      end
    end
  end

  // Byte-enabled write at the accepting edge
  always_ff @(posedge clk_i) begin
    if (accept && req_wen_i) begin
      for (int b = 0; b < $bits(be_t); b++) begin
        if (req_be_i[b]) begin
          mem_q[bank][row][8*b +: 8] <= req_wdata_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_o <= 1'b0;
    end else if (req_ready_o) begin
      rd_valid_o <= accept && !req_wen_i;  // Writes give no response
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && !req_wen_i) begin
      rd_ini_addr_o <= req_ini_addr_i;
      rd_blen_o     <= req_len;
      rd_split_o    <= req_split_i;
      rd_data_o     <= rd_row;
    end
  end

  // Cutter keeps every read inside one row
  a_row_local: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i && !req_wen_i |-> int'(bank) + int'(req_len) <= `TCDM_NUM_BANKS)
    else $error("Read runs past the last bank");

endmodule

// File: tcdm_bank_array/tcdm_resp_merger.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Response merger
// Joins the two cuts of a split burst into one initiator response
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "tcdm_burst_defines.svh"

module tcdm_resp_merger (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Read data from the banks
  input  logic                      rd_valid_i,
  output logic                      rd_ready_o,
  input  tcdm_burst_pkg::id_t       rd_ini_addr_i,
  input  tcdm_burst_pkg::blen_t     rd_blen_i,
  input  logic                      rd_split_i,   // First part of a pair
  input  tcdm_burst_pkg::row_data_t rd_data_i,
  // Response to the initiator
  output logic                      resp_valid_o,
  input  logic                      resp_ready_i,
  output tcdm_burst_pkg::id_t       resp_ini_addr_o,
  output tcdm_burst_pkg::blen_t     resp_blen_o,
  output tcdm_burst_pkg::row_data_t resp_rdata_o
);

  import tcdm_burst_pkg::*;

  // Partial buffer for a pending first part
  logic      part_valid_q;
  blen_t     part_blen_q;
  row_data_t part_data_q;

  row_data_t merged_data;
  blen_t     merged_blen;
  logic      accept;

  assign rd_ready_o = !resp_valid_o || resp_ready_i;  // Output free or draining
  assign accept     = rd_valid_i && rd_ready_o;

  // Second part lands behind the stored words, unused words are zero
  always_comb begin
    if (part_valid_q) begin
      merged_data = part_data_q
                  | row_data_t'(rd_data_i << (int'(part_blen_q) * `TCDM_DATA_WIDTH));
      merged_blen = part_blen_q + rd_blen_i;
    end else begin
      merged_data = rd_data_i;
      merged_blen = rd_blen_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      part_valid_q <= 1'b0;
      resp_valid_o <= 1'b0;
    end else begin
      if (accept) begin
        part_valid_q <= rd_split_i;  // Cleared by the second part
      end
      if (accept && !rd_split_i) begin
        resp_valid_o <= 1'b1;
      end else if (resp_ready_i) begin
        resp_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && rd_split_i) begin
      part_blen_q <= rd_blen_i;
      part_data_q <= rd_data_i;
    end
    if (accept && !rd_split_i) begin
      resp_ini_addr_o <= rd_ini_addr_i;  // Same ID on both parts
      resp_blen_o     <= merged_blen;
      resp_rdata_o    <= merged_data;
    end
  end

  // Cutter never starts a new split before the pair completes
  a_one_partial: assert property (@(posedge clk_i) disable iff (!rst_ni)
    part_valid_q |-> !(rd_valid_i && rd_split_i))
    else $error("Split part arrived with a partial pending");

endmodule

// File: hdl/tcdm_burst_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TCDM burst front end
// Cutter, bank array and response merger behind one initiator port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tcdm_burst_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Initiator request
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  tcdm_burst_pkg::id_t       req_ini_addr_i,
  input  tcdm_burst_pkg::addr_t     req_tgt_addr_i,
  input  logic                      req_wen_i,
  input  tcdm_burst_pkg::data_t     req_wdata_i,
  input  tcdm_burst_pkg::be_t       req_be_i,
  input  tcdm_burst_pkg::burst_t    req_burst_i,
  // Initiator response
  output logic                      resp_valid_o,
  input  logic                      resp_ready_i,
  output tcdm_burst_pkg::id_t       resp_ini_addr_o,
  output tcdm_burst_pkg::blen_t     resp_blen_o,
  output tcdm_burst_pkg::row_data_t resp_rdata_o
);

  import tcdm_burst_pkg::*;

  // Cutter to banks
  logic   cut_valid, cut_ready, cut_wen, cut_split;
  id_t    cut_ini_addr;
  addr_t  cut_tgt_addr;
  data_t  cut_wdata;
  be_t    cut_be;
  burst_t cut_burst;

  // Banks to merger
  logic      rd_valid, rd_ready, rd_split;
  id_t       rd_ini_addr;
  blen_t     rd_blen;
  row_data_t rd_data;

  tcdm_burst_cutter i_cutter (
    .clk_i, .rst_ni,
    .req_valid_i, .req_ready_o, .req_ini_addr_i, .req_tgt_addr_i,
    .req_wen_i, .req_wdata_i, .req_be_i, .req_burst_i,
    .req_valid_o    (cut_valid),
    .req_ready_i    (cut_ready),
    .req_ini_addr_o (cut_ini_addr),
    .req_tgt_addr_o (cut_tgt_addr),
    .req_wen_o      (cut_wen),
    .req_wdata_o    (cut_wdata),
    .req_be_o       (cut_be),
    .req_burst_o    (cut_burst),
    .req_split_o    (cut_split)
  );

  tcdm_bank_array i_banks (
    .clk_i, .rst_ni,
    .req_valid_i    (cut_valid),
    .req_ready_o    (cut_ready),
    .req_ini_addr_i (cut_ini_addr),
    .req_tgt_addr_i (cut_tgt_addr),
    .req_wen_i      (cut_wen),
    .req_wdata_i    (cut_wdata),
    .req_be_i       (cut_be),
    .req_burst_i    (cut_burst),
    .req_split_i    (cut_split),
    .rd_valid_o     (rd_valid),
    .rd_ready_i     (rd_ready),
    .rd_ini_addr_o  (rd_ini_addr),
    .rd_blen_o      (rd_blen),
    .rd_split_o     (rd_split),
    .rd_data_o      (rd_data)
  );

  tcdm_resp_merger i_merger (
    .clk_i, .rst_ni,
    .rd_valid_i     (rd_valid),
    .rd_ready_o     (rd_ready),
    .rd_ini_addr_i  (rd_ini_addr),
    .rd_blen_i      (rd_blen),
    .rd_split_i     (rd_split),
    .rd_data_i      (rd_data),
    .resp_valid_o, .resp_ready_i, .resp_ini_addr_o, .resp_blen_o, .resp_rdata_o
  );

endmodule

// File: bench/tb_tcdm_burst.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TCDM burst front end testbench
// Directed tests against a reference memory model and response queue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "tcdm_burst_defines.svh"

module tb_tcdm_burst;

  import tcdm_burst_pkg::*;

  localparam int NumWords  = `TCDM_NUM_BANKS * `TCDM_NUM_ROWS;
  // Requests per test: fill, byte enables, unsplit, split, back-pressure
  localparam int TestReqs  = (2 * NumWords + 1) + 6 + 12 + 6 + 40;
  localparam int MaxCycles = TestReqs * 4 + 200;

  logic      clk_i;
  logic      rst_ni;
  logic      req_valid, req_ready, req_wen, resp_valid, resp_ready;
  id_t       req_id, resp_id;
  addr_t     req_addr;
  data_t     req_wdata;
  be_t       req_be;
  burst_t    req_burst;
  blen_t     resp_blen;
  row_data_t resp_rdata;

  data_t     ref_mem [NumWords];  // Reference model, flat word address
  id_t       exp_id [$];          // Expected responses in request order
  blen_t     exp_blen [$];
  row_data_t exp_data [$];
  int        exp_cyc [$];         // Negedge count of the response, 0 skips the check
  int        seed;
  int        errors;
  int        cycle_cnt;
  logic      bp_en;               // Random stalls on resp_ready
  logic      ready_next;          // Drawn at the edge, driven 1 ns later

  tcdm_burst_top dut (
    .clk_i, .rst_ni,
    .req_valid_i (req_valid), .req_ready_o (req_ready), .req_ini_addr_i (req_id),
    .req_tgt_addr_i (req_addr), .req_wen_i (req_wen), .req_wdata_i (req_wdata),
    .req_be_i (req_be), .req_burst_i (req_burst),
    .resp_valid_o (resp_valid), .resp_ready_i (resp_ready), .resp_ini_addr_o (resp_id),
    .resp_blen_o (resp_blen), .resp_rdata_o (resp_rdata)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Watchdog, counts edges and stops a hung run
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > MaxCycles) begin
      $display("Timeout, responses still missing after %0d cycles", cycle_cnt);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // Stall draw at the edge itself, request stimulus draws 1 ns later
  always @(posedge clk_i) begin
    ready_next = bp_en ? 1'(($random(seed) & 1)) : 1'b1;  // Stall about half the time
    #1 resp_ready = ready_next;
  end

  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_blen(input blen_t got, input blen_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_id(input id_t got, input id_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Response monitor, samples mid-cycle where outputs are settled
  always @(negedge clk_i) begin
    if (rst_ni && resp_valid && resp_ready) begin
      if (exp_id.size() == 0) begin
        errors++;
        $display("Response arrived at %0t with no request waiting for it", $time);
      end else begin
        check_id(resp_id, exp_id[0], "response ID");
        check_blen(resp_blen, exp_blen[0], "response length");
        for (int k = 0; k < int'(exp_blen[0]); k++) begin
          check_data(resp_rdata[k], exp_data[0][k], $sformatf("response word %0d", k));
        end
        if (exp_cyc[0] != 0 && exp_cyc[0] != cycle_cnt) begin
          errors++;
          $display("ERR %0t: response latency off by %0d cycles", $time,
                   cycle_cnt - exp_cyc[0]);
        end
        void'(exp_id.pop_front());
        void'(exp_blen.pop_front());
        void'(exp_data.pop_front());
        void'(exp_cyc.pop_front());
      end
    end
  end

  // One request, returns at posedge + 1 ns after it transferred
  task automatic send_req(input id_t id, input int word, input logic wen, input data_t wdata,
                          input be_t be, input logic isburst, input int len, input bit chk_lat);
    row_data_t exp;
    int        n;
    req_valid = 1'b1;
    req_id    = id;
    req_addr  = addr_t'(word) << `TCDM_BYTE_OFF_WIDTH;
    req_wen   = wen;
    req_wdata = wdata;
    req_be    = be;
    req_burst = '{isburst: isburst, blen: blen_t'(len)};
    @(negedge clk_i);
    while (!req_ready) @(negedge clk_i);  // Transfers at the coming edge
    if (wen) begin
      for (int b = 0; b < $bits(be_t); b++) begin
        if (be[b]) begin
          ref_mem[word][8*b +: 8] = wdata[8*b +: 8];  // Burst flag ignored
        end
      end
    end else begin
      n   = isburst ? len : 1;
      exp = '0;
      for (int k = 0; k < n; k++) begin
        exp[k] = ref_mem[(word + k) % NumWords];
      end
      exp_id.push_back(id);
      exp_blen.push_back(blen_t'(n));
      exp_data.push_back(exp);
      exp_cyc.push_back(chk_lat ? cycle_cnt + 2 : 0);  // Two edges after acceptance
    end
    @(posedge clk_i);
    #1 req_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_id.size() != 0) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic fill_test();
    for (int w = 0; w < NumWords; w++) begin
      send_req(id_t'(w), w, 1'b1, data_t'($random(seed)), 4'hF, 1'b0, 1, 1'b0);
    end
    send_req(4'd3, 10, 1'b1, data_t'($random(seed)), 4'hF, 1'b1, 4, 1'b0);  // One word only
    for (int w = 0; w < NumWords; w++) begin
      send_req(id_t'(w + 5), w, 1'b0, '0, '0, 1'b0, 1, 1'b0);
    end
    wait_drain();
  endtask

  task automatic byte_enable_test();
    send_req(4'd1, 20, 1'b1, 32'h1122_3344, 4'hF, 1'b0, 1, 1'b0);
    send_req(4'd1, 20, 1'b1, 32'hAABB_CCDD, 4'b0101, 1'b0, 1, 1'b0);
    send_req(4'd2, 20, 1'b0, '0, '0, 1'b0, 1, 1'b0);
    send_req(4'd1, 21, 1'b1, 32'h5566_7788, 4'hF, 1'b0, 1, 1'b0);
    send_req(4'd1, 21, 1'b1, 32'hEE00_0000, 4'b1000, 1'b0, 1, 1'b0);
    send_req(4'd9, 21, 1'b0, '0, '0, 1'b0, 1, 1'b0);
    wait_drain();
  endtask

  task automatic unsplit_test();
    int starts [4] = '{8*3 + 2, 8*9 + 3, 8*12 + 6, 8*15 + 7};
    int lens   [4] = '{3, 5, 2, 1};
    for (int i = 0; i < `TCDM_NUM_BANKS; i++) begin
      send_req(id_t'(i), 8 * (i + 1), 1'b0, '0, '0, 1'b1, i + 1, 1'b1);  // Bank 0 starts
      wait_drain();
    end
    for (int i = 0; i < 4; i++) begin
      send_req(id_t'(i + 10), starts[i], 1'b0, '0, '0, 1'b1, lens[i], 1'b1);
      wait_drain();
    end
  endtask

  task automatic split_test();
    int starts [6] = '{8*2 + 5, 8*4 + 7, 8*6 + 1, 8*15 + 4, 8*10 + 3, 8*11 + 6};
    int lens   [6] = '{6, 8, 8, 8, 7, 3};
    for (int i = 0; i < 6; i++) begin
      send_req(id_t'(15 - i), starts[i], 1'b0, '0, '0, 1'b1, lens[i], 1'b0);
    end
    wait_drain();  // Row 15 start wraps to row 0
  endtask

  task automatic backpressure_test();
    int kind;
    int word;
    int len;
    bp_en = 1'b1;
    for (int i = 0; i < 40; i++) begin
      kind = $random(seed) & 3;
      word = $random(seed) & (NumWords - 1);
      len  = ($random(seed) & 7) + 1;
      case (kind)
        0:       send_req(id_t'(i), word, 1'b1, data_t'($random(seed)), 4'hF, 1'b0, 1, 1'b0);
        1:       send_req(id_t'(i), word, 1'b0, '0, '0, 1'b0, 1, 1'b0);
        default: send_req(id_t'(i), word, 1'b0, '0, '0, 1'b1, len, 1'b0);
      endcase
    end
    wait_drain();
    bp_en = 1'b0;
  endtask

  initial begin
    seed       = 19;
    errors     = 0;
    cycle_cnt  = 0;
    bp_en      = 1'b0;
    rst_ni     = 1'b0;
    req_valid  = 1'b0;
    req_id     = '0;
    req_addr   = '0;
    req_wen    = 1'b0;
    req_wdata  = '0;
    req_be     = '0;
    req_burst  = '0;
    resp_ready = 1'b1;
    repeat (2) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    fill_test();
    byte_enable_test();
    unsplit_test();
    split_test();
    backpressure_test();
    repeat (10) @(posedge clk_i);  // Catch late duplicate responses
    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+common
common/tcdm_burst_pkg.sv
hdl/tcdm_burst_cutter.sv
tcdm_bank_array/tcdm_bank_array.sv
tcdm_bank_array/tcdm_resp_merger.sv
hdl/tcdm_burst_top.sv
bench/tb_tcdm_burst.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the TCDM burst testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_tcdm_burst -o tb_tcdm_burst \
  && ./obj_dir/tb_tcdm_burst > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "^TESTBENCH PASSED$" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
